/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module tb_motion_top -Mdir obj_dir -o tb_motion_top
	./obj_dir/tb_motion_top +verilator+error+limit+1000 | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+rtl
rtl/motion_pkg.sv
rtl/motor_cmd_if.sv
rtl/req_decoder.sv
rtl/motor_channel.sv
rtl/done_collector.sv
rtl/motion_top.sv
sim/motion_top_assert.sv
sim/tb_motion_top.sv

/* rtl/done_collector.sv */
`include "motion_defs.svh"

module done_collector (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  i_req_en,
	input  logic [`MOTOR_NUM-1:0] i_oper_bmp,
	input  logic [`MOTOR_NUM-1:0] i_done,
	output logic                  o_all_done,
	output logic                  o_req_done
);

	logic req_done_q;

	// every operating channel has reported done
	assign o_all_done = (|i_oper_bmp) && ((i_done & i_oper_bmp) == i_oper_bmp);

	always_ff @(posedge clk) begin
		if (!resetn)
			req_done_q <= 1'b0;
		else if (i_req_en)
			req_done_q <= 1'b0;   // any new request clears the flag
		else if (o_all_done)
			req_done_q <= 1'b1;
	end

	assign o_req_done = req_done_q;

endmodule

/* rtl/motion_defs.svh */
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// number of motor channels
`define MOTOR_NUM 4

// motor payload widths
`define SPEED_W 32
`define STEP_W 32

// host request port
`define REQ_CMD_W 32
`define REQ_WORD_W 32
`define REQ_PARAM_W (3 * `REQ_WORD_W)

// command codes 0 .. MOTOR_NUM-1 stage a motor slot
`define CMD_EXE 30
`define CMD_STOP 31

`endif

/* rtl/motion_pkg.sv */
`include "motion_defs.svh"

package motion_pkg;

	// unsigned speed in motor units
	typedef logic [`SPEED_W-1:0] speed_t;

	// relative step count or target position when abs_mode is set
	typedef logic signed [`STEP_W-1:0] step_t;

	// abs_mode sits in bit 0 of parameter word 0
	typedef struct packed {
		logic [`REQ_WORD_W-2:0] spare;
		logic                   abs_mode;
	} req_flags_t;

endpackage

/* rtl/motion_top.sv */
`include "motion_defs.svh"

module motion_top
	import motion_pkg::*;
(
	input  logic                          clk,
	input  logic                          resetn,

	input  logic                          i_req_en,
	input  logic [`REQ_CMD_W-1:0]         i_req_cmd,
	input  logic [`REQ_PARAM_W-1:0]       i_req_param,
	output logic                          o_req_done,

	output logic   [`MOTOR_NUM-1:0]       o_m_start,
	output logic   [`MOTOR_NUM-1:0]       o_m_stop,
	output logic   [`MOTOR_NUM-1:0]       o_m_abs,
	output speed_t [`MOTOR_NUM-1:0]       o_m_speed,
	output step_t  [`MOTOR_NUM-1:0]       o_m_step,
	input  logic   [`MOTOR_NUM-1:0]       i_m_state
);

	logic [`MOTOR_NUM-1:0] oper_bmp;
	logic [`MOTOR_NUM-1:0] done_bmp;
	logic                  all_done;

	motor_cmd_if u_cmd [`MOTOR_NUM] ();

	req_decoder u_decoder (
		.clk         (clk),
		.resetn      (resetn),
		.i_req_en    (i_req_en),
		.i_req_cmd   (i_req_cmd),
		.i_req_param (i_req_param),
		.i_all_done  (all_done),
		.o_oper_bmp  (oper_bmp),
		.o_cmd       (u_cmd)
	);

	// one identical controller per motor
	for (genvar k = 0; k < `MOTOR_NUM; k++) begin : g_channel
		motor_channel u_channel (
			.clk       (clk),
			.resetn    (resetn),
			.i_cmd     (u_cmd[k]),
			.i_m_state (i_m_state[k]),
			.o_m_start (o_m_start[k]),
			.o_m_stop  (o_m_stop[k]),
			.o_m_abs   (o_m_abs[k]),
			.o_m_speed (o_m_speed[k]),
			.o_m_step  (o_m_step[k]),
			.o_done    (done_bmp[k])
		);
	end

	done_collector u_collector (
		.clk        (clk),
		.resetn     (resetn),
		.i_req_en   (i_req_en),
		.i_oper_bmp (oper_bmp),
		.i_done     (done_bmp),
		.o_all_done (all_done),
		.o_req_done (o_req_done)
	);

endmodule

/* rtl/motor_channel.sv */
module motor_channel
	import motion_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	motor_cmd_if.dst i_cmd,
	input  logic     i_m_state,
	output logic     o_m_start,
	output logic     o_m_stop,
	output logic     o_m_abs,
	output speed_t   o_m_speed,
	output step_t    o_m_step,
	output logic     o_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_WAIT_BUSY,
		ST_WAIT_IDLE
	} state_t;

	state_t state;
	logic   run_q;
	logic   stop_q;
	logic   done_q;
	logic   launch;
	logic   abort;

	// a new move only on the rising edge of run
	assign launch = (state == ST_IDLE) && i_cmd.run && !run_q;

	// run dropped while the motor is still ours
	assign abort = (state != ST_IDLE) && !i_cmd.run;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state  <= ST_IDLE;
			run_q  <= 1'b0;
			stop_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			run_q  <= i_cmd.run;
			stop_q <= 1'b0;
			if (abort) begin
				stop_q <= 1'b1;
				state  <= ST_IDLE;
			end else begin
				case (state)
				ST_IDLE: begin
					if (launch) begin
						state <= ST_START;
					end else if (!i_cmd.run) begin
						done_q <= 1'b0;   // release done once the operation is over
					end
				end
				ST_START: begin
					state <= ST_WAIT_BUSY;
				end
				ST_WAIT_BUSY: begin
					if (i_m_state)
						state <= ST_WAIT_IDLE;
				end
				ST_WAIT_IDLE: begin
					if (!i_m_state) begin
						done_q <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// move latched with the start pulse and held until the next launch
	always_ff @(posedge clk) begin
		if (launch) begin
			o_m_abs   <= i_cmd.abs_mode;
			o_m_speed <= i_cmd.speed;
			o_m_step  <= i_cmd.step;
		end
	end

	assign o_m_start = (state == ST_START);
	assign o_m_stop  = stop_q;
	assign o_done    = done_q;

endmodule

/* rtl/motor_cmd_if.sv */
interface motor_cmd_if
	import motion_pkg::*;
();
	logic   run;      // bit of the operating bitmap
	logic   abs_mode;
	speed_t speed;
	step_t  step;

	modport src (
		output run,
		output abs_mode,
		output speed,
		output step
	);

	modport dst (
		input run,
		input abs_mode,
		input speed,
		input step
	);
endinterface

/* rtl/req_decoder.sv */
`include "motion_defs.svh"

module req_decoder
	import motion_pkg::*;
(
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    i_req_en,
	input  logic [`REQ_CMD_W-1:0]   i_req_cmd,
	input  logic [`REQ_PARAM_W-1:0] i_req_param,
	input  logic                    i_all_done,
	output logic [`MOTOR_NUM-1:0]   o_oper_bmp,
	motor_cmd_if.src                o_cmd [`MOTOR_NUM]
);

	req_flags_t req_flags;
	speed_t     req_speed;
	step_t      req_step;

	logic [`MOTOR_NUM-1:0] slot_sel;   // one-hot slot match of i_req_cmd
	logic                  cmd_is_slot;
	logic [`MOTOR_NUM-1:0] stage_bmp;
	logic [`MOTOR_NUM-1:0] oper_bmp;

	// recorded move per slot
	logic [`MOTOR_NUM-1:0] slot_abs;
	speed_t                slot_speed [`MOTOR_NUM];
	step_t                 slot_step  [`MOTOR_NUM];

	// split the parameter words
	assign req_flags = req_flags_t'(i_req_param[`REQ_WORD_W-1:0]);
	assign req_speed = speed_t'(i_req_param[`REQ_WORD_W +: `SPEED_W]);
	assign req_step  = step_t'(i_req_param[2*`REQ_WORD_W +: `STEP_W]);

	assign cmd_is_slot = |slot_sel;

	for (genvar k = 0; k < `MOTOR_NUM; k++) begin : g_slot
		assign slot_sel[k] = (i_req_cmd == `REQ_CMD_W'(k));

		always_ff @(posedge clk) begin
			if (i_req_en && slot_sel[k]) begin
				slot_abs[k]   <= req_flags.abs_mode;
				slot_speed[k] <= req_speed;
				slot_step[k]  <= req_step;
			end
		end

		// a channel runs while its operating bit is set
		assign o_cmd[k].run      = oper_bmp[k];
		assign o_cmd[k].abs_mode = slot_abs[k];
		assign o_cmd[k].speed    = slot_speed[k];
		assign o_cmd[k].step     = slot_step[k];
	end

	// staging and operating bitmaps
	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end else if (i_req_en) begin
			if (cmd_is_slot) begin
				stage_bmp <= stage_bmp | slot_sel;
			end else if (i_req_cmd == `REQ_CMD_W'(`CMD_EXE)) begin
				oper_bmp <= stage_bmp;
			end else if (i_req_cmd == `REQ_CMD_W'(`CMD_STOP)) begin
				stage_bmp <= '0;
				oper_bmp  <= '0;
			end else begin
				stage_bmp <= '0;   // unknown code drops the staged set
			end
		end else if (i_all_done) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end
	end

	assign o_oper_bmp = oper_bmp;

endmodule

/* sim/motion_top_assert.sv */
`include "motion_defs.svh"

module motion_top_assert
	import motion_pkg::*;
(
	input logic                    clk,
	input logic                    resetn,
	input logic                    i_req_en,
	input logic [`REQ_CMD_W-1:0]   i_req_cmd,
	input logic [`REQ_PARAM_W-1:0] i_req_param,
	input logic                    o_req_done,
	input logic [`MOTOR_NUM-1:0]   o_m_start,
	input logic [`MOTOR_NUM-1:0]   o_m_stop,
	input logic [`MOTOR_NUM-1:0]   o_m_abs,
	input speed_t [`MOTOR_NUM-1:0] o_m_speed,
	input step_t [`MOTOR_NUM-1:0]  o_m_step,
	input logic [`MOTOR_NUM-1:0]   i_m_state
);
	timeunit 1ns;
	timeprecision 1ps;

	int errors = 0;   // read by the testbench

	logic [`MOTOR_NUM-1:0] m_stage;
	logic [`MOTOR_NUM-1:0] m_active;   // set launched by the last execute
	logic [`MOTOR_NUM-1:0] m_seen_high;
	logic [`MOTOR_NUM-1:0] m_finished;
	logic [`MOTOR_NUM-1:0] m_abs;
	speed_t                m_speed [`MOTOR_NUM];
	step_t                 m_step [`MOTOR_NUM];
	logic                  seen_exe;
	logic                  req_done_q;
	logic [`MOTOR_NUM-1:0] stage_next;
	logic [`MOTOR_NUM-1:0] active_next;
	logic [`MOTOR_NUM-1:0] fin_now;
	logic [`MOTOR_NUM-1:0] start_d1;
	logic [`MOTOR_NUM-1:0] start_d2;
	logic [`MOTOR_NUM-1:0] stop_d1;
	logic [`MOTOR_NUM-1:0] stop_d2;
	logic                  exe_fire;
	logic                  stop_fire;
	logic                  done_rise;

	assign exe_fire  = i_req_en && (i_req_cmd == `REQ_CMD_W'(`CMD_EXE));
	assign stop_fire = i_req_en && (i_req_cmd == `REQ_CMD_W'(`CMD_STOP));
	assign done_rise = o_req_done && !req_done_q;   // bitmaps cleared one edge earlier
	assign fin_now   = m_seen_high & ~i_m_state;

	// host rules applied to the reference bitmaps
	always_comb begin
		stage_next  = done_rise ? '0 : m_stage;
		active_next = done_rise ? '0 : m_active;
		if (i_req_en) begin
			if (i_req_cmd < `REQ_CMD_W'(`MOTOR_NUM)) begin
				for (int k = 0; k < `MOTOR_NUM; k++) begin
					if (i_req_cmd == `REQ_CMD_W'(k))
						stage_next[k] = 1'b1;
				end
			end else if (exe_fire) begin
				active_next = stage_next;
			end else if (stop_fire) begin
				stage_next  = '0;
				active_next = '0;
			end else begin
				stage_next = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_stage     <= '0;
			m_active    <= '0;
			m_seen_high <= '0;
			m_finished  <= '0;
			seen_exe    <= 1'b0;
			req_done_q  <= 1'b0;
			start_d1    <= '0;
			start_d2    <= '0;
			stop_d1     <= '0;
			stop_d2     <= '0;
		end else begin
			req_done_q  <= o_req_done;
			m_stage     <= stage_next;
			m_active    <= active_next;
			m_seen_high <= m_seen_high | (m_active & i_m_state);
			m_finished  <= m_finished | fin_now;
			start_d1    <= exe_fire ? active_next : '0;
			start_d2    <= start_d1;
			stop_d1     <= stop_fire ? (m_active & ~(m_finished | fin_now)) : '0;
			stop_d2     <= stop_d1;
			if (exe_fire) begin
				seen_exe    <= 1'b1;
				m_seen_high <= '0;
				m_finished  <= '0;
			end
			for (int k = 0; k < `MOTOR_NUM; k++) begin
				if (i_req_en && i_req_cmd == `REQ_CMD_W'(k)) begin
					m_abs[k]   <= i_req_param[0];
					m_speed[k] <= i_req_param[32 +: `SPEED_W];
					m_step[k]  <= i_req_param[64 +: `STEP_W];
				end
			end
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (!resetn)
		!seen_exe |-> (o_m_start == '0 && o_m_stop == '0 && !o_req_done))
	else begin
		$error("motor pulse or completion flag seen before the first execute");
		errors++;
	end

	a_start: assert property (@(posedge clk) disable iff (!resetn) o_m_start == start_d2)
	else begin
		$error("CHECK FAILED o_m_start got %h expected %h",
			$sampled(o_m_start), $sampled(start_d2));
		errors++;
	end

	a_stop: assert property (@(posedge clk) disable iff (!resetn) o_m_stop == stop_d2)
	else begin
		$error("CHECK FAILED o_m_stop got %h expected %h",
			$sampled(o_m_stop), $sampled(stop_d2));
		errors++;
	end

	a_done_rise: assert property (@(posedge clk) disable iff (!resetn)
		$rose(o_req_done) |-> (m_active != '0 && (m_active & ~m_finished) == '0))
	else begin
		$error("o_req_done rose before every started motor went busy and idle again");
		errors++;
	end

	a_done_fall: assert property (@(posedge clk) disable iff (!resetn)
		(o_req_done && i_req_en) |=> !o_req_done)
	else begin
		$error("o_req_done stayed high after a request");
		errors++;
	end

	a_done_hold: assert property (@(posedge clk) disable iff (!resetn)
		$fell(o_req_done) |-> $past(i_req_en))
	else begin
		$error("o_req_done fell without a request");
		errors++;
	end

	for (genvar k = 0; k < `MOTOR_NUM; k++) begin : g_move
		a_speed: assert property (@(posedge clk) disable iff (!resetn)
			o_m_start[k] |-> o_m_speed[k] == m_speed[k])
		else begin
			$error("CHECK FAILED o_m_speed[%0d] got %h expected %h", k,
				$sampled(o_m_speed[k]), $sampled(m_speed[k]));
			errors++;
		end

		a_step: assert property (@(posedge clk) disable iff (!resetn)
			o_m_start[k] |-> o_m_step[k] == m_step[k])
		else begin
			$error("CHECK FAILED o_m_step[%0d] got %h expected %h", k,
				$sampled(o_m_step[k]), $sampled(m_step[k]));
			errors++;
		end

		a_abs: assert property (@(posedge clk) disable iff (!resetn)
			o_m_start[k] |-> o_m_abs[k] == m_abs[k])
		else begin
			$error("CHECK FAILED o_m_abs[%0d] got %h expected %h", k,
				$sampled(o_m_abs[k]), $sampled(m_abs[k]));
			errors++;
		end
	end

endmodule

bind motion_top motion_top_assert u_assert (
	.clk         (clk),
	.resetn      (resetn),
	.i_req_en    (i_req_en),
	.i_req_cmd   (i_req_cmd),
	.i_req_param (i_req_param),
	.o_req_done  (o_req_done),
	.o_m_start   (o_m_start),
	.o_m_stop    (o_m_stop),
	.o_m_abs     (o_m_abs),
	.o_m_speed   (o_m_speed),
	.o_m_step    (o_m_step),
	.i_m_state   (i_m_state)
);

/* sim/tb_motion_top.sv */
`include "motion_defs.svh"

module tb_motion_top
	import motion_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int OP_CYCLES = `MOTOR_NUM + 3 + 8 + 20 + 4;   // staging, start, delay, hold
	localparam int RANDOM_ROUNDS = 4;
	localparam int TEST_CYCLES = 16 + 10 + (RANDOM_ROUNDS + 6) * OP_CYCLES;
	localparam logic [`REQ_CMD_W-1:0] UNUSED_CMD = 17;

	logic                    clk = 1'b0;
	logic                    resetn = 1'b0;
	logic                    req_en = 1'b0;
	logic [`REQ_CMD_W-1:0]   req_cmd = '0;
	logic [`REQ_PARAM_W-1:0] req_param = '0;
	logic                    req_done;
	logic [`MOTOR_NUM-1:0]   m_start;
	logic [`MOTOR_NUM-1:0]   m_stop;
	logic [`MOTOR_NUM-1:0]   m_abs;
	speed_t [`MOTOR_NUM-1:0] m_speed;
	step_t [`MOTOR_NUM-1:0]  m_step;
	logic [`MOTOR_NUM-1:0]   m_state = '0;

	logic [15:0] lfsr = 16'd16157;
	int          fails = 0;
	int          tests = 0;
	int          mark = 0;
	int          wait_cnt [`MOTOR_NUM];
	int          hold_cnt [`MOTOR_NUM];

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	motion_top i_dut (
		.clk         (clk),
		.resetn      (resetn),
		.i_req_en    (req_en),
		.i_req_cmd   (req_cmd),
		.i_req_param (req_param),
		.o_req_done  (req_done),
		.o_m_start   (m_start),
		.o_m_stop    (m_stop),
		.o_m_abs     (m_abs),
		.o_m_speed   (m_speed),
		.o_m_step    (m_step),
		.i_m_state   (m_state)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int error_total();
		return fails + i_dut.u_assert.errors;
	endfunction

	// motor model goes busy 1..8 cycles after start for 2..20 cycles
	always @(negedge clk) begin
		for (int k = 0; k < `MOTOR_NUM; k++) begin
			if (!resetn || m_stop[k]) begin
				wait_cnt[k] = 0;
				hold_cnt[k] = 0;
				m_state[k] = 1'b0;
			end else if (m_start[k]) begin
				wait_cnt[k] = 1 + rand_bits(3);
			end else if (wait_cnt[k] > 0) begin
				wait_cnt[k]--;
				if (wait_cnt[k] == 0) begin
					m_state[k] = 1'b1;
					hold_cnt[k] = 2 + rand_bits(5) % 19;
				end
			end else if (hold_cnt[k] > 0) begin
				hold_cnt[k]--;
				if (hold_cnt[k] == 0)
					m_state[k] = 1'b0;
			end
		end
	end

	// called on a falling edge and returns on the next one
	task automatic send_req(input logic [`REQ_CMD_W-1:0] cmd,
			input logic [`REQ_PARAM_W-1:0] param);
		req_en = 1'b1;
		req_cmd = cmd;
		req_param = param;
		@(negedge clk);
		req_en = 1'b0;
		req_param = '0;
	endtask

	task automatic stage_motor(input int k);
		req_flags_t flags;
		speed_t     speed;
		step_t      step;
		flags = '0;
		flags.abs_mode = 1'(rand_bits(1));
		speed = speed_t'(rand_bits(32));
		step = step_t'(rand_bits(32));
		send_req(`REQ_CMD_W'(k), {step, speed, flags});
	endtask

	task automatic stage_set(input logic [`MOTOR_NUM-1:0] sel);
		for (int k = 0; k < `MOTOR_NUM; k++) begin
			if (sel[k])
				stage_motor(k);
		end
	endtask

	task automatic wait_done(input string what);
		int n;
		n = 0;
		while (!req_done && n < OP_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!req_done) begin
			$display("timeout: o_req_done did not rise during %s", what);
			fails++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (error_total() == mark)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, error_total() - mark);
		mark = error_total();
	endtask

	initial begin
		logic [`MOTOR_NUM-1:0] sel;
		int                    n;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		repeat (10) @(negedge clk);
		end_test("reset idle");

		for (int r = 0; r < RANDOM_ROUNDS; r++) begin
			sel = `MOTOR_NUM'(rand_bits(`MOTOR_NUM));
			if (sel == '0)
				sel[r % `MOTOR_NUM] = 1'b1;
			stage_set(sel);
			send_req(`CMD_EXE, '0);
			wait_done("random set");
			repeat (2) @(negedge clk);
		end
		end_test("random sets");

		stage_motor(1);
		stage_motor(1);   // second write replaces the slot
		send_req(`CMD_EXE, '0);
		wait_done("single channel");
		end_test("single channel");

		sel = '1;
		stage_set(sel);
		send_req(`CMD_EXE, '0);
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (m_state == '0 && n < OP_CYCLES);
		@(negedge clk);
		if (m_state == '0) begin
			$display("no motor went busy before the stop request");
			fails++;
		end
		send_req(`CMD_STOP, '0);
		repeat (OP_CYCLES) @(negedge clk);
		end_test("stop while busy");

		stage_motor(2);
		send_req(UNUSED_CMD, '0);
		send_req(`CMD_EXE, '0);   // nothing left staged
		repeat (12) @(negedge clk);
		end_test("unused code");

		stage_motor(3);
		send_req(`CMD_EXE, '0);
		wait_done("recovery");
		end_test("recovery");

		$display("tests: %0d, check failures: %0d", tests, error_total());
		if (error_total() == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(4 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the test sequence ended");
		$display("Result: FAILED");
		$finish;
	end

endmodule
